/* decode_stage.sv */
/*
 * Field decode, in-bundle hazard check and operand read.
 * A way is issued only if all older ways are issued and it reads no
 * rd written by an older way of the same bundle (r0 excluded).
 * The first rejected way is reported as a replay; ways from it onward
 * are refetched. A redirect turns the whole decode/execute register
 * into bubbles.
 */
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
	input  logic                  clock,
	input  logic                  reset,
	input  ss_pkg::fetch_slot_t   slots_in  [ss_pkg::WAYS],
	input  logic                  redirect_valid,
	input  ss_pkg::commit_t       commit    [ss_pkg::WAYS],
	output ss_pkg::replay_t       replay,
	output ss_pkg::issue_slot_t   slots_out [ss_pkg::WAYS]
);
	import ss_pkg::*;

	issue_slot_t     dec [WAYS];
	logic [WAYS-1:0] uses_rs1;
	logic [WAYS-1:0] uses_rs2;
	logic [WAYS-1:0] writes_rd;
	logic [WAYS-1:0] accept;
	logic            older_ok;
	logic            hazard;
	reg_idx_t        rd_idx  [2*WAYS];
	data_t           rd_data [2*WAYS];

	// two read ports per way, rs1 then rs2
	always_comb begin
		for (int w = 0; w < WAYS; w++) begin
			rd_idx[2*w]   = slots_in[w].instr[8:6];
			rd_idx[2*w+1] = slots_in[w].instr[5:3];
		end
	end

	reg_file u_reg_file (
		.clock   (clock),
		.reset   (reset),
		.wr      (commit),
		.rd_idx  (rd_idx),
		.rd_data (rd_data)
	);

	////////////////////
	// decode and hazard check
	always_comb begin
		for (int w = 0; w < WAYS; w++) begin
			dec[w].pc      = slots_in[w].pc;
			dec[w].op      = opcode_e'(slots_in[w].instr[15:12]);
			dec[w].rd      = slots_in[w].instr[11:9];
			dec[w].rs1     = rd_idx[2*w];
			dec[w].rs2     = rd_idx[2*w+1];
			dec[w].rs1_val = rd_data[2*w];
			dec[w].rs2_val = rd_data[2*w+1];
			if (dec[w].op == OP_ADDI)
				dec[w].imm = data_t'(signed'(slots_in[w].instr[5:0]));
			else
				dec[w].imm = data_t'(slots_in[w].instr[5:0]);  // bnz target
			uses_rs1[w]  = dec[w].op inside {OP_ADD, OP_SUB, OP_ADDI, OP_BNZ};
			uses_rs2[w]  = dec[w].op inside {OP_ADD, OP_SUB};
			writes_rd[w] = dec[w].op inside {OP_ADD, OP_SUB, OP_ADDI};
		end

		older_ok = 1'b1;
		for (int w = 0; w < WAYS; w++) begin
			hazard = 1'b0;
			for (int j = 0; j < w; j++) begin
				if (accept[j] && writes_rd[j] && dec[j].rd != '0 &&
						((uses_rs1[w] && dec[j].rd == dec[w].rs1) ||
						 (uses_rs2[w] && dec[j].rd == dec[w].rs2)))
					hazard = 1'b1;
			end
			accept[w]    = older_ok && slots_in[w].valid && !hazard;
			older_ok     = accept[w];
			dec[w].valid = accept[w];
		end

		replay = '0;
		for (int w = WAYS-1; w >= 0; w--) begin  // oldest rejected way last
			if (slots_in[w].valid && !accept[w]) begin
				replay.valid = 1'b1;
				replay.pc    = slots_in[w].pc;
			end
		end
	end

	////////////////////
	// decode/execute register
	always_ff @(posedge clock) begin
		for (int w = 0; w < WAYS; w++) begin
			slots_out[w] <= dec[w];
			if (!reset || redirect_valid)
				slots_out[w].valid <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* exec_stage.sv */
/*
 * Forwarding, ALUs, branch and halt resolution, execute/writeback reg.
 * Operands are forwarded only from this stage's own output register;
 * older results come through the register file write-through.
 * The oldest taken bnz or halt redirects fetch and squashes the younger
 * ways of its bundle. nop, bnz and halt commit with data 0.
 */
`timescale 1ns/1ps
`default_nettype none

module exec_stage (
	input  logic                  clock,
	input  logic                  reset,
	input  ss_pkg::issue_slot_t   slots_in [ss_pkg::WAYS],
	output ss_pkg::redirect_t     redirect,
	output ss_pkg::commit_t       commit   [ss_pkg::WAYS]
);
	import ss_pkg::*;

	data_t           op_a   [WAYS];
	data_t           op_b   [WAYS];
	data_t           result [WAYS];
	logic [WAYS-1:0] fires;  // taken bnz or halt
	logic            squash;
	commit_t         nxt    [WAYS];

	////////////////////
	// forwarding and ALUs
	always_comb begin
		for (int w = 0; w < WAYS; w++) begin
			op_a[w] = slots_in[w].rs1_val;
			op_b[w] = slots_in[w].rs2_val;
			for (int c = 0; c < WAYS; c++) begin  // youngest match wins
				if (commit[c].valid && commit[c].wr_en && commit[c].rd != '0) begin
					if (commit[c].rd == slots_in[w].rs1)
						op_a[w] = commit[c].data;
					if (commit[c].rd == slots_in[w].rs2)
						op_b[w] = commit[c].data;
				end
			end

			case (slots_in[w].op)
				OP_ADD:  result[w] = op_a[w] + op_b[w];
				OP_SUB:  result[w] = op_a[w] - op_b[w];
				OP_ADDI: result[w] = op_a[w] + slots_in[w].imm;
				default: result[w] = '0;
			endcase

			fires[w] = slots_in[w].valid &&
				((slots_in[w].op == OP_BNZ && op_a[w] != '0) ||
				 slots_in[w].op == OP_HALT);
		end
	end

	////////////////////
	// redirect and squash
	always_comb begin
		redirect = '0;
		squash   = 1'b0;
		for (int w = 0; w < WAYS; w++) begin
			nxt[w].valid = slots_in[w].valid && !squash;
			nxt[w].pc    = slots_in[w].pc;
			nxt[w].wr_en = slots_in[w].op inside {OP_ADD, OP_SUB, OP_ADDI};
			nxt[w].rd    = slots_in[w].rd;
			nxt[w].data  = result[w];
			nxt[w].stop  = (slots_in[w].op == OP_HALT);
			if (fires[w] && !squash) begin
				squash          = 1'b1;  // younger ways dropped
				redirect.valid  = 1'b1;
				redirect.stop   = nxt[w].stop;
				redirect.target = nxt[w].stop ? slots_in[w].pc :
					slots_in[w].imm[PC_W-1:0];
			end
		end
	end

	// execute/writeback register
	always_ff @(posedge clock) begin
		for (int w = 0; w < WAYS; w++) begin
			commit[w] <= nxt[w];
			if (!reset)
				commit[w].valid <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* fetch_unit.sv */
/*
 * Program counter and fetch/decode register.
 * imem_data must hold the words at imem_addr..imem_addr+2 in the same
 * cycle; there is no handshake and fetch never stalls.
 * A redirect with stop set halts fetch until reset.
 */
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
	input  logic                  clock,
	input  logic                  reset,
	input  ss_pkg::redirect_t     redirect,
	input  ss_pkg::replay_t       replay,
	output ss_pkg::pc_t           imem_addr,
	input  ss_pkg::bundle_t       imem_data,
	output ss_pkg::fetch_slot_t   slots [ss_pkg::WAYS]
);
	import ss_pkg::*;

	pc_t  pc;
	pc_t  next_pc;
	logic stopped;  // sticky after halt
	logic drop;     // current bundle is discarded

	assign imem_addr = pc;
	assign drop      = redirect.valid || replay.valid || stopped;

	always_comb begin
		if (redirect.valid)
			next_pc = redirect.target;
		else if (replay.valid)
			next_pc = replay.pc;  // refetch rejected ways
		else if (stopped)
			next_pc = pc;
		else
			next_pc = pc + pc_t'(WAYS);
	end

	always_ff @(posedge clock) begin
		if (!reset) begin
			pc      <= '0;
			stopped <= 1'b0;
		end else begin
			pc      <= next_pc;
			stopped <= stopped | (redirect.valid & redirect.stop);
		end
	end

	////////////////////
	// fetch/decode register
	always_ff @(posedge clock) begin
		for (int w = 0; w < WAYS; w++) begin
			slots[w].pc    <= pc + pc_t'(w);
			slots[w].instr <= imem_data[w];
			slots[w].valid <= !drop;
			if (!reset)
				slots[w].valid <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* flist.f */
ss_pkg.sv
reg_file.sv
fetch_unit.sv
decode_stage.sv
exec_stage.sv
ss_pipeline.sv
tb_clock.sv
tb_ss_pipeline.sv

/* reg_file.sv */
/*
 * Eight-entry register file, three write ports and six read ports.
 * Reads see a write of the same cycle. With several writes to one
 * register the highest way wins. r0 reads zero; reset clears all.
 */
`timescale 1ns/1ps
`default_nettype none

module reg_file (
	input  logic                clock,
	input  logic                reset,
	input  ss_pkg::commit_t     wr     [ss_pkg::WAYS],
	input  ss_pkg::reg_idx_t    rd_idx [2*ss_pkg::WAYS],
	output ss_pkg::data_t       rd_data [2*ss_pkg::WAYS]
);
	import ss_pkg::*;

	data_t regs [2**REG_W];

	always_ff @(posedge clock) begin
		if (!reset) begin
			for (int r = 0; r < 2**REG_W; r++)
				regs[r] <= '0;
		end else begin
			for (int w = 0; w < WAYS; w++) begin  // later ways override
				if (wr[w].valid && wr[w].wr_en && wr[w].rd != '0)
					regs[wr[w].rd] <= wr[w].data;
			end
		end
	end

	// write-through, youngest way last
	always_comb begin
		for (int p = 0; p < 2*WAYS; p++) begin
			rd_data[p] = regs[rd_idx[p]];
			for (int w = 0; w < WAYS; w++) begin
				if (wr[w].valid && wr[w].wr_en && wr[w].rd == rd_idx[p])
					rd_data[p] = wr[w].data;
			end
			if (rd_idx[p] == '0)
				rd_data[p] = '0;  // r0 hardwired
		end
	end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Verilator build and run of the ss_pipeline testbench.
# Exit status is 0 only when the simulation log holds the pass line.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f flist.f --top-module tb_ss_pipeline \
		-o tb_ss_pipeline; then
	echo "verilator build failed"
	exit 1
fi

if ! ./obj_dir/tb_ss_pipeline > sim.log 2>&1; then
	cat sim.log
	echo "simulation exited with an error"
	exit 1
fi
cat sim.log

if grep -qx "ALL CHECKS PASSED" sim.log; then
	exit 0
fi
exit 1

/* ss_pipeline.sv */
/*
 * Top level of the four-stage, three-way in-order pipeline.
 * imem is a combinational three-word read port at imem_addr.
 * commit shows the retired ways each cycle, way 0 oldest.
 * halted rises the edge after a halt commits and holds until reset.
 */
`timescale 1ns/1ps
`default_nettype none

module ss_pipeline (
	input  logic              clock,
	input  logic              reset,
	output ss_pkg::pc_t       imem_addr,
	input  ss_pkg::bundle_t   imem_data,
	output ss_pkg::commit_t   commit [ss_pkg::WAYS],
	output logic              halted
);
	import ss_pkg::*;

	fetch_slot_t fd_slots [WAYS];  // fetch/decode
	issue_slot_t de_slots [WAYS];  // decode/execute
	redirect_t   redirect;
	replay_t     replay;

	fetch_unit u_fetch (
		.clock     (clock),
		.reset     (reset),
		.redirect  (redirect),
		.replay    (replay),
		.imem_addr (imem_addr),
		.imem_data (imem_data),
		.slots     (fd_slots)
	);

	decode_stage u_decode (
		.clock          (clock),
		.reset          (reset),
		.slots_in       (fd_slots),
		.redirect_valid (redirect.valid),
		.commit         (commit),
		.replay         (replay),
		.slots_out      (de_slots)
	);

	exec_stage u_exec (
		.clock    (clock),
		.reset    (reset),
		.slots_in (de_slots),
		.redirect (redirect),
		.commit   (commit)
	);

	always_ff @(posedge clock) begin
		if (!reset)
			halted <= 1'b0;
		else
			for (int w = 0; w < WAYS; w++)
				if (commit[w].valid && commit[w].stop)
					halted <= 1'b1;  // sticky
	end

endmodule

`default_nettype wire

/* ss_pkg.sv */
/*
 * Shared widths, opcodes and stage records for the three-way pipeline.
 * Instruction format: op[15:12] rd[11:9] rs1[8:6] rs2[5:3] imm[5:0].
 * The immediate is sign-extended for addi and zero-extended as an
 * absolute instruction index for bnz. Way 0 is always the oldest.
 */
`default_nettype none

package ss_pkg;

	localparam int WAYS  = 3;  // instructions per bundle
	localparam int XLEN  = 16;
	localparam int PC_W  = 8;  // instruction index, not a byte address
	localparam int REG_W = 3;

	typedef logic [XLEN-1:0]  data_t;
	typedef logic [PC_W-1:0]  pc_t;
	typedef logic [REG_W-1:0] reg_idx_t;
	typedef logic [15:0]      instr_t;

	typedef enum logic [3:0] {
		OP_NOP  = 4'h0,
		OP_ADD  = 4'h1,
		OP_SUB  = 4'h2,
		OP_ADDI = 4'h3,
		OP_BNZ  = 4'h4,  // taken when rs1 != 0
		OP_HALT = 4'h5
	} opcode_e;

	typedef instr_t [WAYS-1:0] bundle_t;  // index 0 = oldest

	typedef struct packed {
		logic   valid;
		pc_t    pc;
		instr_t instr;
	} fetch_slot_t;

	typedef struct packed {
		logic     valid;
		pc_t      pc;
		opcode_e  op;
		reg_idx_t rd;
		reg_idx_t rs1;
		reg_idx_t rs2;
		data_t    rs1_val;  // as read in decode, before forwarding
		data_t    rs2_val;
		data_t    imm;
	} issue_slot_t;

	typedef struct packed {
		logic     valid;
		pc_t      pc;
		logic     wr_en;
		reg_idx_t rd;
		data_t    data;
		logic     stop;  // set on the halt commit
	} commit_t;

	typedef struct packed {
		logic valid;
		pc_t  target;
		logic stop;
	} redirect_t;

	typedef struct packed {
		logic valid;
		pc_t  pc;  // first rejected way, refetched from here
	} replay_t;

endpackage

`default_nettype wire

/* tb_clock.sv */
/*
 * Free-running testbench clock, 40 ns period.
 * Starts low at time zero, first rising edge at 20 ns.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
	output logic clock
);

	initial clock = 1'b0;

	always #20 clock = ~clock;  // half period

endmodule

`default_nettype wire

/* tb_ss_pipeline.sv */
/*
 * Directed testbench for ss_pipeline.
 * Instruction memory is a 256-word array read combinationally.
 * Unused words hold nop. Expected commits come from an in-order model of the
 * instruction set. Every program must end in halt.
 * The stop bit of commit is not compared.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_ss_pipeline;
	import ss_pkg::*;

	localparam int NUM_TESTS  = 5;
	localparam int HALT_WAIT  = 30;  // cycles a program may take
	localparam int MAX_CYCLES = 40*NUM_TESTS + 20;

	logic    clock;
	logic    reset;
	pc_t     imem_addr;
	bundle_t imem_data;
	commit_t commit [WAYS];
	logic    halted;

	instr_t  prog [256];
	int      prog_len;
	commit_t exp_q [$];
	commit_t got_q [$];
	int      errors = 0;
	int      checks = 0;
	int      cycles = 0;
	int      last_commit_cyc;
	int      rise_cyc;

	tb_clock u_clock (
		.clock (clock)
	);

	ss_pipeline u_ss_pipeline (
		.clock     (clock),
		.reset     (reset),
		.imem_addr (imem_addr),
		.imem_data (imem_data),
		.commit    (commit),
		.halted    (halted)
	);

	// three-word read port, wraps at 256
	always_comb begin
		for (int w = 0; w < WAYS; w++)
			imem_data[w] = prog[imem_addr + pc_t'(w)];
	end

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: run went past %0d cycles", MAX_CYCLES);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	// retired ways, way 0 first
	always @(negedge clock) begin
		if (reset) begin
			for (int w = 0; w < WAYS; w++) begin
				if (commit[w].valid) begin
					got_q.push_back(commit[w]);
					last_commit_cyc = cycles;
				end
			end
			if (halted && rise_cyc < 0)
				rise_cyc = cycles;
		end
	end

	////////////////////
	// checks
	function automatic string fmt_commit(commit_t c);
		return $sformatf("v=%b pc=%0d we=%b rd=%0d data=%h", c.valid, c.pc, c.wr_en, c.rd,
			c.data);
	endfunction

	task automatic check_commit(input string name, input commit_t want, input commit_t seen);
		checks++;
		if (seen.valid !== want.valid || seen.pc !== want.pc || seen.wr_en !== want.wr_en ||
				seen.rd !== want.rd || seen.data !== want.data) begin
			errors++;
			$display("[FAIL] %0t %s: expected %s, got %s", $time, name, fmt_commit(want),
				fmt_commit(seen));
		end
	endtask

	task automatic check_flag(input string name, input logic want, input logic seen);
		checks++;
		if (seen !== want) begin
			errors++;
			$display("[FAIL] %0t %s: expected %b, got %b", $time, name, want, seen);
		end
	endtask

	task automatic check_pc(input string name, input pc_t want, input pc_t seen);
		checks++;
		if (seen !== want) begin
			errors++;
			$display("[FAIL] %0t %s: expected %0d, got %0d", $time, name, want, seen);
		end
	endtask

	task automatic check_count(input string name, input int want, input int seen);
		checks++;
		if (seen != want) begin
			errors++;
			$display("[FAIL] %0t %s: expected %0d, got %0d", $time, name, want, seen);
		end
	endtask

	task automatic check_idle(input string when);
		for (int w = 0; w < WAYS; w++)
			check_flag($sformatf("commit[%0d].valid %s", w, when), 1'b0, commit[w].valid);
		check_flag({"halted ", when}, 1'b0, halted);
	endtask

	////////////////////
	// program and reference model
	function automatic instr_t enc(opcode_e op, int rd, int rs1, int low);
		return {op, 3'(rd), 3'(rs1), 6'(low)};
	endfunction

	function automatic instr_t enc_r(opcode_e op, int rd, int rs1, int rs2);
		return enc(op, rd, rs1, rs2 * 8);  // rs2 sits in bits 5..3
	endfunction

	task automatic clear_program();
		prog_len = 0;
		for (int i = 0; i < 256; i++)
			prog[i] = enc(OP_NOP, 0, 0, 0);
	endtask

	task automatic put_instr(input instr_t ins);
		prog[prog_len] = ins;
		prog_len++;
	endtask

	task automatic build_expected();
		data_t   regs [8];
		pc_t     pc;
		instr_t  ins;
		opcode_e op;
		data_t   a;
		data_t   b;
		data_t   imm;
		commit_t e;
		pc = '0;
		exp_q.delete();
		for (int r = 0; r < 8; r++)
			regs[r] = '0;
		for (int step = 0; step < 64; step++) begin
			ins     = prog[pc];
			op      = opcode_e'(ins[15:12]);
			a       = regs[ins[8:6]];
			b       = regs[ins[5:3]];
			imm     = {{(XLEN-6){ins[5]}}, ins[5:0]};
			e       = '0;
			e.valid = 1'b1;
			e.pc    = pc;
			e.rd    = ins[11:9];
			e.stop  = (op == OP_HALT);
			e.wr_en = (op == OP_ADD || op == OP_SUB || op == OP_ADDI);
			if (op == OP_ADD)
				e.data = a + b;
			else if (op == OP_SUB)
				e.data = a - b;
			else if (op == OP_ADDI)
				e.data = a + imm;
			exp_q.push_back(e);
			if (e.wr_en && e.rd != '0)
				regs[e.rd] = e.data;
			if (op == OP_HALT)
				break;
			pc = (op == OP_BNZ && a != '0) ? pc_t'(ins[5:0]) : pc + pc_t'(1);
		end
	endtask

	////////////////////
	// test sequencing
	task automatic apply_reset();
		@(posedge clock);
		#2 reset = 1'b0;
		got_q.delete();
		last_commit_cyc = -1;
		rise_cyc = -1;
		repeat (5) begin
			@(posedge clock);
			#1 check_idle("in reset");
		end
		check_pc("imem_addr in reset", '0, imem_addr);
		#1 reset = 1'b1;
		@(posedge clock);
		#1 check_idle("after reset");
	endtask

	task automatic run_program(input string name);
		int waited;
		waited = 0;
		build_expected();
		apply_reset();
		while (!halted && waited < HALT_WAIT) begin
			@(negedge clock);
			waited++;
		end
		if (!halted) begin
			errors++;
			$display("%s: program did not reach halt within %0d cycles", name, HALT_WAIT);
		end else begin
			repeat (3) @(negedge clock);  // catch stray commits after halt
			check_count({name, " commit count"}, exp_q.size(), got_q.size());
			for (int i = 0; i < exp_q.size() && i < got_q.size(); i++)
				check_commit($sformatf("%s commit %0d", name, i), exp_q[i], got_q[i]);
			check_flag({name, " halted one edge after halt"}, 1'b1,
				rise_cyc == last_commit_cyc + 1);
		end
	endtask

	task automatic test_independent();
		int v [4];
		for (int k = 0; k < 4; k++)
			v[k] = $urandom % 64;
		clear_program();
		put_instr(enc(OP_ADDI, 1, 0, v[0]));
		put_instr(enc(OP_ADDI, 2, 0, v[1]));
		put_instr(enc(OP_ADDI, 3, 0, v[2]));
		put_instr(enc_r(OP_ADD, 4, 1, 2));
		put_instr(enc_r(OP_SUB, 5, 3, 1));
		put_instr(enc_r(OP_SUB, 7, 2, 3));
		put_instr(enc(OP_ADDI, 0, 1, v[3]));  // r0 write, no hazard
		put_instr(enc_r(OP_ADD, 6, 0, 3));
		put_instr(enc(OP_NOP, 0, 0, 0));
		put_instr(enc_r(OP_SUB, 2, 5, 0));  // r0 one bundle later
		put_instr(enc(OP_HALT, 0, 0, 0));
		run_program("independent");
	endtask

	task automatic test_chain();
		int v [3];
		for (int k = 0; k < 3; k++)
			v[k] = $urandom % 64;
		clear_program();
		put_instr(enc(OP_ADDI, 1, 0, v[0]));
		put_instr(enc(OP_ADDI, 2, 0, v[1]));
		put_instr(enc(OP_NOP, 0, 0, 0));
		put_instr(enc_r(OP_ADD, 3, 1, 2));
		put_instr(enc_r(OP_SUB, 4, 2, 1));
		put_instr(enc(OP_NOP, 0, 0, 0));
		put_instr(enc_r(OP_ADD, 5, 3, 4));
		put_instr(enc(OP_ADDI, 6, 1, v[2]));
		put_instr(enc(OP_NOP, 0, 0, 0));
		put_instr(enc_r(OP_SUB, 7, 5, 3));
		put_instr(enc_r(OP_ADD, 1, 6, 5));
		put_instr(enc(OP_NOP, 0, 0, 0));
		put_instr(enc(OP_HALT, 0, 0, 0));
		run_program("chain");
	endtask

	task automatic test_in_bundle_hazard();
		clear_program();
		put_instr(enc(OP_ADDI, 1, 0, 5));
		put_instr(enc(OP_ADDI, 3, 0, 9));
		put_instr(enc_r(OP_ADD, 2, 1, 1));  // way 2 reads way 0
		put_instr(enc(OP_ADDI, 4, 0, 2));
		put_instr(enc_r(OP_SUB, 6, 3, 4));  // way 2 reads way 1 once refetched from 2
		put_instr(enc_r(OP_ADD, 7, 6, 2));  // way 1 reads way 0
		put_instr(enc(OP_ADDI, 7, 7, 1));
		put_instr(enc_r(OP_ADD, 1, 7, 3));
		put_instr(enc(OP_HALT, 0, 0, 0));
		run_program("in-bundle hazard");
	endtask

	task automatic test_branches();
		clear_program();
		put_instr(enc(OP_ADDI, 1, 0, 1));
		put_instr(enc(OP_ADDI, 2, 0, 0));
		put_instr(enc(OP_NOP, 0, 0, 0));
		put_instr(enc(OP_BNZ, 0, 1, 8));  // taken from way 0
		put_instr(enc(OP_ADDI, 3, 0, 11));
		put_instr(enc(OP_ADDI, 3, 0, 12));
		put_instr(enc(OP_ADDI, 4, 0, 13));
		put_instr(enc(OP_ADDI, 4, 0, 14));
		put_instr(enc(OP_BNZ, 0, 2, 20));  // not taken
		put_instr(enc(OP_BNZ, 0, 1, 14));  // taken from way 1
		put_instr(enc(OP_ADDI, 5, 0, 15));
		put_instr(enc(OP_ADDI, 6, 0, 1));
		put_instr(enc(OP_ADDI, 6, 0, 2));
		put_instr(enc(OP_ADDI, 6, 0, 3));
		put_instr(enc(OP_ADDI, 5, 5, 21));
		put_instr(enc(OP_HALT, 0, 0, 0));
		run_program("branches");
	endtask

	task automatic test_halt_mid_bundle();
		clear_program();
		put_instr(enc(OP_ADDI, 1, 0, 4));
		put_instr(enc(OP_HALT, 0, 0, 0));
		put_instr(enc(OP_ADDI, 2, 0, 7));
		put_instr(enc(OP_ADDI, 3, 0, 8));
		put_instr(enc_r(OP_ADD, 4, 1, 1));
		put_instr(enc(OP_HALT, 0, 0, 0));
		run_program("halt");
	endtask

	initial begin
		reset = 1'b0;
		clear_program();
		void'($urandom(34));
		test_independent();
		test_chain();
		test_in_bundle_hazard();
		test_branches();
		test_halt_mid_bundle();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire
